//--- core_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizes, unit and operation codes, and the request/response structs
// shared by the L1 caches, store buffer and L2 arbiter of one core.
// Modules import it inside their body and use scoped names in ports.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package core_pkg;

	localparam int NUM_STRANDS = 4;
	localparam int STRAND_W = 2;
	localparam int ADDR_W = 16;		// Byte address
	localparam int LINE_ADDR_W = 12;	// Address without lane and byte bits
	localparam int LINE_W = 128;
	localparam int WORD_W = 32;
	localparam int NUM_SETS = 16;
	localparam int SET_W = 4;
	localparam int TAG_W = 8;
	localparam int LANE_W = 2;		// Four words per line
	localparam int MASK_W = 4;		// One bit per byte of a word

	// Who issued an L2 request, echoed back in the response
	typedef enum logic [1:0] {
		UNIT_ICACHE = 2'd0,
		UNIT_DCACHE = 2'd1,
		UNIT_STBUF = 2'd2
	} unit_t;

	typedef enum logic {
		OP_LOAD_LINE = 1'b0,
		OP_STORE_WORD = 1'b1
	} op_t;

	typedef struct packed {
		unit_t unit;
		logic [STRAND_W-1:0] strand;
		op_t op;
		logic [LINE_ADDR_W-1:0] line_addr;
		logic [WORD_W-1:0] data;	// Store data, unused for line loads
		logic [MASK_W-1:0] mask;
		logic [LANE_W-1:0] lane;
	} l2_req_t;

	// For a store the data field carries the whole line after the store
	typedef struct packed {
		logic valid;
		unit_t unit;
		logic [STRAND_W-1:0] strand;
		op_t op;
		logic [LINE_ADDR_W-1:0] line_addr;
		logic [LINE_W-1:0] data;
	} l2_rsp_t;

	typedef struct packed {
		logic access;
		logic [STRAND_W-1:0] strand;
		logic [ADDR_W-1:0] addr;
	} cache_req_t;

endpackage

//--- l1_cache.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped L1 cache, one line fill in flight at a time.
// UNIT selects instruction or data behavior. The data cache also
// takes in store responses that hit a resident line.
// Hit and word come out one cycle after the access.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module l1_cache #(
	parameter core_pkg::unit_t UNIT = core_pkg::UNIT_ICACHE
) (
	input  logic clk,
	input  logic reset,
	input  core_pkg::cache_req_t req_i,
	output logic hit_o,
	output logic [core_pkg::WORD_W-1:0] word_o,
	output logic [core_pkg::NUM_STRANDS-1:0] load_complete_o,
	output logic l2req_valid_o,
	output core_pkg::l2_req_t l2req_o,
	input  logic l2req_ready_i,
	input  core_pkg::l2_rsp_t l2rsp_i
);
	import core_pkg::*;

	logic [TAG_W-1:0] tag_mem [NUM_SETS];
	logic [LINE_W-1:0] data_mem [NUM_SETS];
	logic [NUM_SETS-1:0] line_valid;

	logic [LINE_ADDR_W-1:0] req_line;
	logic [SET_W-1:0] req_set;
	logic [TAG_W-1:0] req_tag;
	logic [SET_W-1:0] wr_set;
	logic [TAG_W-1:0] wr_tag;
	logic fill_en;
	logic update_en;
	logic write_en;
	logic lookup_hit;
	logic [LINE_W-1:0] lookup_line;
	logic miss;
	logic issue_req;
	logic [NUM_STRANDS-1:0] strand_bit;

	logic fill_pending;
	logic [NUM_STRANDS-1:0] wait_mask;	// Strands waiting on the fill
	logic [LINE_W-1:0] line_q;
	logic [LANE_W-1:0] lane_q;

	assign req_line = req_i.addr[ADDR_W-1:ADDR_W-LINE_ADDR_W];
	assign req_set = req_line[SET_W-1:0];
	assign req_tag = req_line[LINE_ADDR_W-1:SET_W];
	assign wr_set = l2rsp_i.line_addr[SET_W-1:0];
	assign wr_tag = l2rsp_i.line_addr[LINE_ADDR_W-1:SET_W];
	assign strand_bit = NUM_STRANDS'(1) << req_i.strand;

	assign fill_en = l2rsp_i.valid && l2rsp_i.unit == UNIT && l2rsp_i.op == OP_LOAD_LINE;

	// Store responses only patch a line that is already resident
	assign update_en = UNIT == UNIT_DCACHE && l2rsp_i.valid && l2rsp_i.op == OP_STORE_WORD
		&& line_valid[wr_set] && tag_mem[wr_set] == wr_tag;
	assign write_en = fill_en || update_en;

	// Line written this cycle is forwarded to a lookup of the same set
	always_comb
	begin
		if (write_en && wr_set == req_set)
		begin
			lookup_hit = wr_tag == req_tag;
			lookup_line = l2rsp_i.data;
		end
		else
		begin
			lookup_hit = line_valid[req_set] && tag_mem[req_set] == req_tag;
			lookup_line = data_mem[req_set];
		end
	end

	assign miss = req_i.access && !lookup_hit;
	assign issue_req = miss && !fill_pending && !fill_en;

	always_ff @(posedge clk)
	begin
		if (write_en)
		begin
			data_mem[wr_set] <= l2rsp_i.data;
			tag_mem[wr_set] <= wr_tag;
		end
		line_q <= lookup_line;
		lane_q <= req_i.addr[LANE_W+1:2];
		if (issue_req)
		begin
			l2req_o.unit <= UNIT;
			l2req_o.strand <= req_i.strand;
			l2req_o.op <= OP_LOAD_LINE;
			l2req_o.line_addr <= req_line;
			l2req_o.data <= '0;
			l2req_o.mask <= '0;
			l2req_o.lane <= '0;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			line_valid <= '0;
			hit_o <= 1'b0;
			load_complete_o <= '0;
			fill_pending <= 1'b0;
			wait_mask <= '0;
			l2req_valid_o <= 1'b0;
		end
		else
		begin
			hit_o <= req_i.access && lookup_hit;
			load_complete_o <= '0;
			if (fill_en)
				line_valid[wr_set] <= 1'b1;

			if (l2req_valid_o && l2req_ready_i)
				l2req_valid_o <= 1'b0;	// Arbiter took it

			if (fill_en)
			begin
				// A strand missing right now is woken too and just retries
				load_complete_o <= wait_mask | (miss ? strand_bit : '0);
				wait_mask <= '0;
				fill_pending <= 1'b0;
			end
			else if (miss)
			begin
				wait_mask <= wait_mask | strand_bit;
				if (!fill_pending)
				begin
					fill_pending <= 1'b1;
					l2req_valid_o <= 1'b1;
				end
			end
		end
	end

	assign word_o = line_q[lane_q * WORD_W +: WORD_W];	// Lane select

endmodule

//--- store_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Store buffer with one pending store per strand.
// Sends each new store to L2 as a word write, strands taken in turn,
// rolls back a store to a busy entry, and merges the pending store
// into load data returned by the data cache.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module store_buffer (
	input  logic clk,
	input  logic reset,
	input  logic store_valid_i,
	input  logic [core_pkg::STRAND_W-1:0] store_strand_i,
	input  logic [core_pkg::ADDR_W-1:0] store_addr_i,
	input  logic [core_pkg::WORD_W-1:0] store_data_i,
	input  logic [core_pkg::MASK_W-1:0] store_mask_i,
	input  logic [core_pkg::STRAND_W-1:0] load_strand_i,
	input  logic [core_pkg::ADDR_W-1:0] load_addr_i,
	input  logic [core_pkg::WORD_W-1:0] cache_word_i,
	output logic [core_pkg::WORD_W-1:0] word_o,
	output logic rollback_o,
	output logic [core_pkg::NUM_STRANDS-1:0] store_resume_o,
	output logic l2req_valid_o,
	output core_pkg::l2_req_t l2req_o,
	input  logic l2req_ready_i,
	input  core_pkg::l2_rsp_t l2rsp_i
);
	import core_pkg::*;

	logic [NUM_STRANDS-1:0] entry_valid;
	logic [NUM_STRANDS-1:0] entry_sent;	// Already handed to the arbiter
	logic [ADDR_W-1:0] entry_addr [NUM_STRANDS];
	logic [WORD_W-1:0] entry_data [NUM_STRANDS];
	logic [MASK_W-1:0] entry_mask [NUM_STRANDS];

	logic [NUM_STRANDS-1:0] pending;
	logic [STRAND_W-1:0] rr_ptr;
	logic [STRAND_W-1:0] pick;
	logic pick_found;
	logic capture;
	logic store_accept;
	logic store_done;
	logic [STRAND_W-1:0] load_strand_q;
	logic [ADDR_W-1:0] load_addr_q;
	logic forward;

	assign store_accept = store_valid_i && !entry_valid[store_strand_i];
	assign store_done = l2rsp_i.valid && l2rsp_i.unit == UNIT_STBUF
		&& l2rsp_i.op == OP_STORE_WORD;
	assign pending = entry_valid & ~entry_sent;
	assign capture = pick_found && (!l2req_valid_o || l2req_ready_i);

	// Round robin from the strand after the last one sent
	always_comb
	begin : rr_pick
		logic [STRAND_W-1:0] idx;

		pick = rr_ptr;
		pick_found = 1'b0;
		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			idx = rr_ptr + STRAND_W'(i);
			if (!pick_found && pending[idx])
			begin
				pick = idx;
				pick_found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			entry_valid <= '0;
			entry_sent <= '0;
			rr_ptr <= '0;
			l2req_valid_o <= 1'b0;
			rollback_o <= 1'b0;
			store_resume_o <= '0;
		end
		else
		begin
			rollback_o <= store_valid_i && entry_valid[store_strand_i];
			store_resume_o <= '0;
			if (store_done)
			begin
				entry_valid[l2rsp_i.strand] <= 1'b0;
				store_resume_o[l2rsp_i.strand] <= 1'b1;
			end
			if (store_accept)
			begin
				entry_valid[store_strand_i] <= 1'b1;
				entry_sent[store_strand_i] <= 1'b0;
			end
			if (capture)
			begin
				entry_sent[pick] <= 1'b1;
				rr_ptr <= pick + 1'b1;
				l2req_valid_o <= 1'b1;
			end
			else if (l2req_ready_i)
				l2req_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (store_accept)
		begin
			entry_addr[store_strand_i] <= store_addr_i;
			entry_data[store_strand_i] <= store_data_i;
			entry_mask[store_strand_i] <= store_mask_i;
		end
		if (capture)
		begin
			l2req_o.unit <= UNIT_STBUF;
			l2req_o.strand <= pick;
			l2req_o.op <= OP_STORE_WORD;
			l2req_o.line_addr <= entry_addr[pick][ADDR_W-1:ADDR_W-LINE_ADDR_W];
			l2req_o.data <= entry_data[pick];
			l2req_o.mask <= entry_mask[pick];
			l2req_o.lane <= entry_addr[pick][LANE_W+1:2];
		end
		load_strand_q <= load_strand_i;	// Lines up with the cache hit
		load_addr_q <= load_addr_i;
	end

	// Bytes under the store mask are forwarded when the word address matches
	assign forward = entry_valid[load_strand_q]
		&& entry_addr[load_strand_q][ADDR_W-1:2] == load_addr_q[ADDR_W-1:2];

	always_comb
	begin
		for (int b = 0; b < MASK_W; b++)
		begin
			if (forward && entry_mask[load_strand_q][b])
				word_o[b*8 +: 8] = entry_data[load_strand_q][b*8 +: 8];
			else
				word_o[b*8 +: 8] = cache_word_i[b*8 +: 8];
		end
	end

endmodule

//--- l2req_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Merges the store buffer, data cache and instruction cache requests
// onto the single L2 request port, in that order of priority.
// The chosen source sees ready in the cycle it is captured.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module l2req_arbiter (
	input  logic clk,
	input  logic reset,
	input  logic icache_valid_i,
	input  core_pkg::l2_req_t icache_req_i,
	output logic icache_ready_o,
	input  logic dcache_valid_i,
	input  core_pkg::l2_req_t dcache_req_i,
	output logic dcache_ready_o,
	input  logic stbuf_valid_i,
	input  core_pkg::l2_req_t stbuf_req_i,
	output logic stbuf_ready_o,
	output logic l2req_valid_o,
	output core_pkg::l2_req_t l2req_o,
	input  logic l2req_ready_i
);
	import core_pkg::*;

	logic can_capture;
	logic any_valid;
	l2_req_t grant_req;

	// Output register empty, or emptying this cycle
	assign can_capture = !l2req_valid_o || l2req_ready_i;
	assign any_valid = stbuf_valid_i || dcache_valid_i || icache_valid_i;

	assign stbuf_ready_o = can_capture && stbuf_valid_i;
	assign dcache_ready_o = can_capture && dcache_valid_i && !stbuf_valid_i;
	assign icache_ready_o = can_capture && icache_valid_i && !stbuf_valid_i
		&& !dcache_valid_i;

	always_comb
	begin
		if (stbuf_valid_i)
			grant_req = stbuf_req_i;
		else if (dcache_valid_i)
			grant_req = dcache_req_i;
		else
			grant_req = icache_req_i;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			l2req_valid_o <= 1'b0;
		else if (can_capture)
			l2req_valid_o <= any_valid;
	end

	always_ff @(posedge clk)
	begin
		if (can_capture && any_valid)
			l2req_o <= grant_req;	// Held while L2 stalls
	end

endmodule

//--- core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory side of one core: instruction and data caches, store buffer
// and the L2 request arbiter. The pipeline drives the cache and store
// ports; L2 sits behind the request and response ports.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module core (
	input  logic clk,
	input  logic reset,
	input  core_pkg::cache_req_t icache_req_i,
	output logic icache_hit_o,
	output logic [core_pkg::WORD_W-1:0] icache_word_o,
	output logic [core_pkg::NUM_STRANDS-1:0] icache_complete_o,
	input  core_pkg::cache_req_t dcache_req_i,
	output logic dcache_hit_o,
	output logic [core_pkg::WORD_W-1:0] load_word_o,
	output logic [core_pkg::NUM_STRANDS-1:0] dcache_complete_o,
	input  logic store_valid_i,
	input  logic [core_pkg::STRAND_W-1:0] store_strand_i,
	input  logic [core_pkg::ADDR_W-1:0] store_addr_i,
	input  logic [core_pkg::WORD_W-1:0] store_data_i,
	input  logic [core_pkg::MASK_W-1:0] store_mask_i,
	output logic rollback_o,
	output logic [core_pkg::NUM_STRANDS-1:0] store_resume_o,
	output logic l2req_valid_o,
	output core_pkg::l2_req_t l2req_o,
	input  logic l2req_ready_i,
	input  core_pkg::l2_rsp_t l2rsp_i
);
	import core_pkg::*;

	logic icache_l2req_valid;
	l2_req_t icache_l2req;
	logic icache_l2req_ready;
	logic dcache_l2req_valid;
	l2_req_t dcache_l2req;
	logic dcache_l2req_ready;
	logic stbuf_l2req_valid;
	l2_req_t stbuf_l2req;
	logic stbuf_l2req_ready;
	logic [WORD_W-1:0] dcache_word;	// Before store forwarding

	l1_cache #(.UNIT(UNIT_ICACHE)) icache (
		.clk(clk),
		.reset(reset),
		.req_i(icache_req_i),
		.hit_o(icache_hit_o),
		.word_o(icache_word_o),
		.load_complete_o(icache_complete_o),
		.l2req_valid_o(icache_l2req_valid),
		.l2req_o(icache_l2req),
		.l2req_ready_i(icache_l2req_ready),
		.l2rsp_i(l2rsp_i)
	);

	l1_cache #(.UNIT(UNIT_DCACHE)) dcache (
		.clk(clk),
		.reset(reset),
		.req_i(dcache_req_i),
		.hit_o(dcache_hit_o),
		.word_o(dcache_word),
		.load_complete_o(dcache_complete_o),
		.l2req_valid_o(dcache_l2req_valid),
		.l2req_o(dcache_l2req),
		.l2req_ready_i(dcache_l2req_ready),
		.l2rsp_i(l2rsp_i)
	);

	store_buffer stbuf (
		.clk(clk),
		.reset(reset),
		.store_valid_i(store_valid_i),
		.store_strand_i(store_strand_i),
		.store_addr_i(store_addr_i),
		.store_data_i(store_data_i),
		.store_mask_i(store_mask_i),
		.load_strand_i(dcache_req_i.strand),
		.load_addr_i(dcache_req_i.addr),
		.cache_word_i(dcache_word),
		.word_o(load_word_o),
		.rollback_o(rollback_o),
		.store_resume_o(store_resume_o),
		.l2req_valid_o(stbuf_l2req_valid),
		.l2req_o(stbuf_l2req),
		.l2req_ready_i(stbuf_l2req_ready),
		.l2rsp_i(l2rsp_i)
	);

	l2req_arbiter arbiter (
		.clk(clk),
		.reset(reset),
		.icache_valid_i(icache_l2req_valid),
		.icache_req_i(icache_l2req),
		.icache_ready_o(icache_l2req_ready),
		.dcache_valid_i(dcache_l2req_valid),
		.dcache_req_i(dcache_l2req),
		.dcache_ready_o(dcache_l2req_ready),
		.stbuf_valid_i(stbuf_l2req_valid),
		.stbuf_req_i(stbuf_l2req),
		.stbuf_ready_o(stbuf_l2req_ready),
		.l2req_valid_o(l2req_valid_o),
		.l2req_o(l2req_o),
		.l2req_ready_i(l2req_ready_i)
	);

endmodule

//--- core_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent checks on the L2 request port of the arbiter.
// Bound into l2req_arbiter from the testbench.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module core_assert (
	input  logic clk,
	input  logic reset,
	input  logic l2req_valid_o,
	input  core_pkg::l2_req_t l2req_o,
	input  logic l2req_ready_i,
	input  logic icache_ready_o,
	input  logic dcache_ready_o,
	input  logic stbuf_ready_o
);

	// Stalled request keeps valid and payload
	hold_req: assert property (@(posedge clk) disable iff (reset)
		l2req_valid_o && !l2req_ready_i |=> l2req_valid_o && $stable(l2req_o))
		else $error("L2 request dropped or changed while stalled");

	one_grant: assert property (@(posedge clk) disable iff (reset)
		$onehot0({icache_ready_o, dcache_ready_o, stbuf_ready_o}))
		else $error("More than one source granted in a cycle");

	idle_in_reset: assert property (@(posedge clk) reset |-> !l2req_valid_o)
		else $error("L2 request valid during reset");

endmodule

//--- core_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the core memory side. Plays the pipeline from the
// vectors in core_tests.txt and plays L2 with a word array, random
// back-pressure and a fixed response latency.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module core_tb;
	import core_pkg::*;

	localparam int MEM_WORDS = 16384;	// 64 KB of 32-bit words
	localparam int L2_LATENCY = 3;
	localparam int CYCLES_PER_TEST = 64;

	logic clk;
	logic reset;
	cache_req_t icache_req_i;
	logic icache_hit_o;
	logic [WORD_W-1:0] icache_word_o;
	logic [NUM_STRANDS-1:0] icache_complete_o;
	cache_req_t dcache_req_i;
	logic dcache_hit_o;
	logic [WORD_W-1:0] load_word_o;
	logic [NUM_STRANDS-1:0] dcache_complete_o;
	logic store_valid_i;
	logic [STRAND_W-1:0] store_strand_i;
	logic [ADDR_W-1:0] store_addr_i;
	logic [WORD_W-1:0] store_data_i;
	logic [MASK_W-1:0] store_mask_i;
	logic rollback_o;
	logic [NUM_STRANDS-1:0] store_resume_o;
	logic l2req_valid_o;
	l2_req_t l2req_o;
	logic l2req_ready_i;
	l2_rsp_t l2rsp_i;

	logic [31:0] mem [MEM_WORDS];
	string t_name[$];
	string t_op[$];
	logic [31:0] t_strand[$];
	logic [31:0] t_addr[$];
	logic [31:0] t_data[$];
	logic [31:0] t_mask[$];
	logic [31:0] t_exp[$];
	int cycle_count = 0;
	int cycle_limit = 0;

	core u_core (.*);

	bind l2req_arbiter core_assert u_assert (.*);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;

		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Lane 0 sits in the low bits of the line
	function automatic logic [LINE_W-1:0] line_of(input logic [LINE_ADDR_W-1:0] la);
		return {mem[{la, 2'd3}], mem[{la, 2'd2}], mem[{la, 2'd1}], mem[{la, 2'd0}]};
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("FAILED %s expected %08h actual %08h", name, expected, actual);
			$display("Verification failed");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	// L2 model drives ready and the response
	initial
	begin : l2_model
		logic [31:0] rng;
		int l2_cycle;
		l2_rsp_t rsp_q[$];
		int due_q[$];
		l2_rsp_t rsp;
		logic [13:0] widx;

		rng = 32'hd7e5da05;
		l2_cycle = 0;
		l2req_ready_i = 1'b0;
		l2rsp_i = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = 32'hA000_0000 + i;	// Word address pattern
		forever
		begin
			@(negedge clk);
			l2_cycle++;
			rng = xorshift(rng);
			l2req_ready_i = rng[1:0] != 2'b00;	// Stall about one cycle in four
			if (due_q.size() > 0 && due_q[0] <= l2_cycle)
			begin
				l2rsp_i = rsp_q.pop_front();
				void'(due_q.pop_front());
			end
			else
				l2rsp_i = '0;
			// Taken at the coming rising edge
			if (l2req_valid_o && l2req_ready_i)
			begin
				widx = {l2req_o.line_addr, l2req_o.lane};
				if (l2req_o.op == OP_STORE_WORD)
					for (int b = 0; b < MASK_W; b++)
						if (l2req_o.mask[b])
							mem[widx][b*8 +: 8] = l2req_o.data[b*8 +: 8];
				rsp.valid = 1'b1;
				rsp.unit = l2req_o.unit;
				rsp.strand = l2req_o.strand;
				rsp.op = l2req_o.op;
				rsp.line_addr = l2req_o.line_addr;
				rsp.data = line_of(l2req_o.line_addr);
				rsp_q.push_back(rsp);
				due_q.push_back(l2_cycle + L2_LATENCY);
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit)
		begin
			$display("Timeout: tests did not finish within %0d cycles", cycle_limit);
			$display("Verification failed");
			$fatal(1, "Run aborted on timeout");
		end
	end

	// One access from one falling edge to the next
	task automatic probe(input logic is_data, input logic [1:0] strand,
		input logic [15:0] addr, output logic hit, output logic [31:0] word,
		output logic [3:0] done);
		cache_req_t req;

		req.access = 1'b1;
		req.strand = strand;
		req.addr = addr;
		if (is_data)
			dcache_req_i = req;
		else
			icache_req_i = req;
		@(negedge clk);
		dcache_req_i = '0;
		icache_req_i = '0;
		hit = is_data ? dcache_hit_o : icache_hit_o;
		word = is_data ? load_word_o : icache_word_o;
		done = is_data ? dcache_complete_o : icache_complete_o;
	endtask

	task automatic wait_complete(input logic is_data, input logic [3:0] need,
		input logic [3:0] seen);
		logic [3:0] got;

		got = seen;
		while ((got & need) != need)
		begin
			@(negedge clk);
			got = got | (is_data ? dcache_complete_o : icache_complete_o);
		end
	endtask

	task automatic read_until_hit(input logic is_data, input logic [1:0] strand,
		input logic [15:0] addr, output logic [31:0] word);
		logic hit;
		logic [3:0] done;

		probe(is_data, strand, addr, hit, word, done);
		while (!hit)
		begin
			wait_complete(is_data, 4'(1) << strand, done);
			probe(is_data, strand, addr, hit, word, done);
		end
	endtask

	task automatic store_word(input int idx, input logic wait_resume);
		logic rb;
		logic first;

		first = 1'b1;
		do
		begin
			store_valid_i = 1'b1;
			store_strand_i = t_strand[idx][1:0];
			store_addr_i = t_addr[idx][15:0];
			store_data_i = t_data[idx];
			store_mask_i = t_mask[idx][3:0];
			@(negedge clk);
			store_valid_i = 1'b0;
			rb = rollback_o;
			if (first)
				check({t_name[idx], ".rollback"}, t_exp[idx], {31'd0, rb});
			first = 1'b0;
		end
		while (rb);
		if (wait_resume)
			while (!store_resume_o[t_strand[idx][1:0]])
				@(negedge clk);
	endtask

	// Two strands miss on one line back to back and then both hit
	task automatic dual_load(input int idx);
		logic [1:0] sa;
		logic [1:0] sb;
		logic hit_a;
		logic hit_b;
		logic [31:0] word;
		logic [3:0] done_a;
		logic [3:0] done_b;

		sa = t_strand[idx][1:0];
		sb = sa + 2'd1;
		probe(1'b1, sa, t_addr[idx][15:0], hit_a, word, done_a);
		probe(1'b1, sb, t_addr[idx][15:0], hit_b, word, done_b);
		check({t_name[idx], ".first_miss_a"}, 0, {31'd0, hit_a});
		check({t_name[idx], ".first_miss_b"}, 0, {31'd0, hit_b});
		wait_complete(1'b1, (4'(1) << sa) | (4'(1) << sb), done_a | done_b);
		probe(1'b1, sa, t_addr[idx][15:0], hit_a, word, done_a);
		check({t_name[idx], ".hit_a"}, 1, {31'd0, hit_a});
		check({t_name[idx], ".word_a"}, t_exp[idx], word);
		probe(1'b1, sb, t_addr[idx][15:0], hit_b, word, done_b);
		check({t_name[idx], ".hit_b"}, 1, {31'd0, hit_b});
		check({t_name[idx], ".word_b"}, t_exp[idx], word);
	endtask

	task automatic read_tests();
		int fd;
		int n;
		string line;
		string name;
		string op;
		logic [31:0] v[5];

		fd = $fopen("core_tests.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open the test vector file core_tests.txt");
			$display("Verification failed");
			$fatal(1, "No stimulus");
		end
		while ($fgets(line, fd) > 0)
		begin
			if (line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%s %s %h %h %h %h %h", name, op, v[0], v[1], v[2], v[3], v[4]);
			if (n != 7)
				continue;
			t_name.push_back(name);
			t_op.push_back(op);
			t_strand.push_back(v[0]);
			t_addr.push_back(v[1]);
			t_data.push_back(v[2]);
			t_mask.push_back(v[3]);
			t_exp.push_back(v[4]);
		end
		$fclose(fd);
	endtask

	initial
	begin : main
		logic hit;
		logic [31:0] word;
		logic [3:0] done;

		reset = 1'b1;
		icache_req_i = '0;
		dcache_req_i = '0;
		store_valid_i = 1'b0;
		store_strand_i = '0;
		store_addr_i = '0;
		store_data_i = '0;
		store_mask_i = '0;
		read_tests();
		cycle_limit = t_name.size() * CYCLES_PER_TEST;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		for (int i = 0; i < t_name.size(); i++)
		begin
			case (t_op[i])
				"fetch", "load":
				begin
					read_until_hit(t_op[i] == "load", t_strand[i][1:0], t_addr[i][15:0], word);
					check(t_name[i], t_exp[i], word);
				end
				"fhit":
				begin
					probe(1'b0, t_strand[i][1:0], t_addr[i][15:0], hit, word, done);
					check({t_name[i], ".hit"}, 1, {31'd0, hit});
					check(t_name[i], t_exp[i], word);
				end
				"post":
				begin
					// Line resident so the next load hits while the store is pending
					read_until_hit(1'b1, t_strand[i][1:0], t_addr[i][15:0], word);
					store_word(i, 1'b0);	// Leaves the entry busy
				end
				"store": store_word(i, 1'b1);
				"dual": dual_load(i);
				default:
				begin
					$display("Unknown operation %s in test %s", t_op[i], t_name[i]);
					$display("Verification failed");
					$fatal(1, "Bad test vector");
				end
			endcase
		end
		$display("Verification passed");
		$finish;
	end

endmodule

//--- core_tests.txt
# name op strand addr data mask expected (hex; store expected = first-try rollback)
# ops: fetch/load retry until hit, fhit must hit at once, post leaves the store pending
f_miss fetch 0 0148 00000000 0 A0000052
f_hit fhit 1 0140 00000000 0 A0000050
st_post post 2 2204 11223344 3 00000000
ld_fwd load 2 2204 00000000 0 A0003344
st_done store 1 3008 CAFEBABE F 00000000
ld_other load 3 3008 00000000 0 CAFEBABE
ld_pre load 0 4010 00000000 0 A0001004
st_upd store 0 4010 5555AAAA C 00000000
ld_upd load 1 4010 00000000 0 55551004
st_busy1 post 3 5000 01020304 F 00000000
st_busy2 store 3 5000 0A0B0C0D F 00000001
ld_busy load 0 5000 00000000 0 0A0B0C0D
ld_pair dual 1 6024 00000000 0 A0001809
ld_set load 3 2200 00000000 0 A0000880
f_top fetch 2 7FFC 00000000 0 A0001FFF
ld_again load 0 3008 00000000 0 CAFEBABE
f_store fetch 3 3008 00000000 0 CAFEBABE
ld_mem load 1 2204 00000000 0 A0003344

//--- files.f
core_pkg.sv
l1_cache.sv
store_buffer.sv
l2req_arbiter.sv
core.sv
core_assert.sv
core_tb.sv

//--- run.sh
#!/bin/bash
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module core_tb -o core_sim

./obj_dir/core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
	exit 1
fi
if ! grep -q "Verification passed" sim.log; then
	exit 1
fi
exit 0
